// ==== logic/gf64_settings.svh ====
/*
 * Shared constants of the GF64 butterfly accelerator: field, bus and register map.
 * Included by the package and by every module that needs a width or an address.
 */
`ifndef GF64_SETTINGS_SVH
`define GF64_SETTINGS_SVH

// Goldilocks field, p = 2^64 - 2^32 + 1
`define GF64_MOD_W    64
`define GF64_PRIME    64'hFFFF_FFFF_0000_0001

// Wishbone data width and word address width
`define GF64_WB_DW    32
`define GF64_WB_AW    4

// Round count carried by a CTRL write
`define GF64_ROUND_W  8

// --------------------------------------------------
// Register word addresses
// --------------------------------------------------
`define GF64_REG_A_LO   4'd0
`define GF64_REG_A_HI   4'd1
`define GF64_REG_B_LO   4'd2
`define GF64_REG_B_HI   4'd3
`define GF64_REG_CTRL   4'd4
`define GF64_REG_STATUS 4'd5
`define GF64_REG_X_LO   4'd6
`define GF64_REG_X_HI   4'd7
`define GF64_REG_Y_LO   4'd8
`define GF64_REG_Y_HI   4'd9

`endif

// ==== logic/gf64_pkg.sv ====
/*
 * Types shared by the GF64 butterfly blocks.
 * Modules name these types in their ports and import the package in their bodies.
 */
`default_nettype none
`include "gf64_settings.svh"

package gf64_pkg;

  // Working pair of the butterfly, x in the upper half
  typedef struct packed {
    logic [`GF64_MOD_W-1:0] x;
    logic [`GF64_MOD_W-1:0] y;
  } gf64_pair_t;

  // Field view of a 66-bit two's complement word
  typedef struct packed {
    logic                   sign;
    logic                   carry;
    logic [`GF64_MOD_W-1:0] low;
  } gf64_sword_f_t;

  // Pre-reduction word, built as raw bits, reduced through its fields
  typedef union packed {
    logic [`GF64_MOD_W+1:0] raw;
    gf64_sword_f_t          f;
  } gf64_sword_u;

  // Sequencer states, also decoded into STATUS
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    WAIT  = 2'd2,
    DONE  = 2'd3
  } gf64_seq_state_t;

endpackage

`default_nettype wire

// ==== logic/gf64_pmr_sign.sv ====
/*
 * Partial modular reduction of a signed 66-bit word to 65 unsigned bits.
 * Two register stages, fully pipelined, one word accepted per cycle.
 */
`timescale 1ns/1ns
`default_nettype none
`include "gf64_settings.svh"

module gf64_pmr_sign (
  input  logic                  clk,
  input  logic                  rst,
  input  gf64_pkg::gf64_sword_u a,
  input  logic                  in_avail,
  output logic [`GF64_MOD_W:0]  z,
  output logic                  out_avail
);
  import gf64_pkg::*;

  localparam int MID_W = `GF64_MOD_W / 2;
  // Sign weight -2^65 folds to -(2^33 - 2), plus p to stay nonnegative
  localparam logic [`GF64_MOD_W:0] SIGN_FOLD =
    {1'b0, `GF64_PRIME} - ({{`GF64_MOD_W{1'b0}}, 1'b1} << (MID_W + 1)) + 2;

  gf64_sword_u           s0_a;
  logic [`GF64_MOD_W:0]  s0_carry_fold;
  logic [`GF64_MOD_W:0]  s0_sign_fold;
  logic [`GF64_MOD_W:0]  s0_z;
  logic [1:0]            avail_sr;

  // --------------------------------------------------
  // Stage 0, input register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    s0_a <= a;
  end

  // Carry at 2^64 is worth 2^32 - 1, i.e. 32 low ones
  assign s0_carry_fold = {{(MID_W + 1){1'b0}}, {MID_W{s0_a.f.carry}}};
  assign s0_sign_fold  = s0_a.f.sign ? SIGN_FOLD : '0;

  // Sum stays below 2^65 for any input pattern
  assign s0_z = {1'b0, s0_a.f.low} + s0_carry_fold + s0_sign_fold;

  // --------------------------------------------------
  // Stage 1, output register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    z <= s0_z;
  end

  // Valid flag follows the two data stages
  always_ff @(posedge clk) begin
    if (rst) begin
      avail_sr <= 2'b00;
    end else begin
      avail_sr <= {avail_sr[0], in_avail};
    end
  end

  assign out_avail = avail_sr[1];

endmodule

`default_nettype wire

// ==== logic/gf64_bfly_unit.sv ====
/*
 * One GF64 butterfly round on the working pair: (x, y) -> (x + y, x - y) mod p.
 * load copies the operands in, issue launches a round, round_done marks write-back.
 */
`timescale 1ns/1ns
`default_nettype none
`include "gf64_settings.svh"

module gf64_bfly_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  gf64_pkg::gf64_pair_t operands,
  input  logic                 issue,
  output gf64_pkg::gf64_pair_t pair,
  output logic                 round_done
);
  import gf64_pkg::*;

  gf64_sword_u            sum_w;
  gf64_sword_u            diff_w;
  logic [`GF64_MOD_W:0]   sum_z;
  logic [`GF64_MOD_W:0]   diff_z;
  logic                   sum_avail;
  logic                   diff_avail;
  logic                   wb_en;

  // Bring a 65-bit value below p, it can hold up to two multiples of p
  function automatic logic [`GF64_MOD_W-1:0] canon(input logic [`GF64_MOD_W:0] v);
    logic [`GF64_MOD_W:0] t;
    t = v;
    if (t >= {1'b0, `GF64_PRIME}) begin
      t = t - {1'b0, `GF64_PRIME};
    end
    if (t >= {1'b0, `GF64_PRIME}) begin
      t = t - {1'b0, `GF64_PRIME};
    end
    return t[`GF64_MOD_W-1:0];
  endfunction

  // --------------------------------------------------
  // Add and subtract paths
  // --------------------------------------------------
  // Sum zero-extended, never sets the sign bit
  assign sum_w.raw  = {2'b00, pair.x} + {2'b00, pair.y};
  // Difference wraps to two's complement when y > x
  assign diff_w.raw = {2'b00, pair.x} - {2'b00, pair.y};

  gf64_pmr_sign sum_pmr (
    .clk       (clk),
    .rst       (rst),
    .a         (sum_w),
    .in_avail  (issue),
    .z         (sum_z),
    .out_avail (sum_avail)
  );

  gf64_pmr_sign diff_pmr (
    .clk       (clk),
    .rst       (rst),
    .a         (diff_w),
    .in_avail  (issue),
    .z         (diff_z),
    .out_avail (diff_avail)
  );

  assign wb_en = sum_avail & diff_avail;

  // --------------------------------------------------
  // Final reduction and write-back
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pair       <= '0;
      round_done <= 1'b0;
    end else begin
      round_done <= wb_en;
      if (load) begin
        pair <= operands;
      end else if (wb_en) begin
        pair.x <= canon(sum_z);
        pair.y <= canon(diff_z);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/gf64_round_counter.sv ====
/*
 * Remaining round count of the butterfly engine.
 * Loaded with R at start, counted down once per finished round.
 */
`timescale 1ns/1ns
`default_nettype none
`include "gf64_settings.svh"

module gf64_round_counter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cnt_load,
  input  logic [`GF64_ROUND_W-1:0] rounds,
  input  logic                     dec,
  output logic                     zero
);

  logic [`GF64_ROUND_W-1:0] count;
  logic [`GF64_ROUND_W-1:0] count_next;

  // Load wins over decrement, count saturates at zero
  always_comb begin
    count_next = count;
    if (cnt_load) begin
      count_next = rounds;
    end else if (dec && (count != '0)) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  // Flag reflects the count after this cycle's load or decrement
  assign zero = (count_next == '0);

endmodule

`default_nettype wire

// ==== logic/gf64_sequencer.sv ====
/*
 * Control FSM of the butterfly engine.
 * Loads the operands, then issues one round at a time until the counter runs out.
 */
`timescale 1ns/1ns
`default_nettype none

module gf64_sequencer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic                      zero,
  input  logic                      round_done,
  output logic                      load,
  output logic                      cnt_load,
  output logic                      issue,
  output logic                      dec,
  output gf64_pkg::gf64_seq_state_t state
);
  import gf64_pkg::*;

  gf64_seq_state_t state_next;

  // Start is only taken while no run is in progress
  assign load     = start && ((state == IDLE) || (state == DONE));
  assign cnt_load = load;
  assign issue    = (state == ISSUE);
  // One count per written-back round
  assign dec      = round_done;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      IDLE, DONE: begin
        // zero here already reflects the freshly loaded R
        if (load) begin
          state_next = zero ? DONE : ISSUE;
        end
      end
      ISSUE: begin
        state_next = WAIT;
      end
      WAIT: begin
        // zero here reflects the count after this round
        if (round_done) begin
          state_next = zero ? DONE : ISSUE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

// ==== logic/gf64_wb_regs.sv ====
/*
 * Wishbone classic slave register block of the butterfly engine.
 * Holds operands A and B, takes R and start from CTRL, returns STATUS and results.
 */
`timescale 1ns/1ns
`default_nettype none
`include "gf64_settings.svh"

module gf64_wb_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [`GF64_WB_AW-1:0]     adr,
  input  logic [`GF64_WB_DW-1:0]     dat_w,
  input  logic [`GF64_WB_DW/8-1:0]   sel,
  output logic [`GF64_WB_DW-1:0]     dat_r,
  output logic                       ack,
  input  gf64_pkg::gf64_seq_state_t  state,
  input  gf64_pkg::gf64_pair_t       pair,
  output gf64_pkg::gf64_pair_t       operands,
  output logic                       start,
  output logic [`GF64_ROUND_W-1:0]   rounds
);
  import gf64_pkg::*;

  logic                   req;
  logic                   busy;
  logic                   done;
  logic [`GF64_MOD_W-1:0] a_reg;
  logic [`GF64_MOD_W-1:0] b_reg;
  logic [`GF64_WB_DW-1:0] rd_data;

  // Byte-lane merge of a bus word into a register word
  function automatic logic [`GF64_WB_DW-1:0] lane_merge(
    input logic [`GF64_WB_DW-1:0]   old_w,
    input logic [`GF64_WB_DW-1:0]   new_w,
    input logic [`GF64_WB_DW/8-1:0] be
  );
    logic [`GF64_WB_DW-1:0] res;
    res = old_w;
    for (int i = 0; i < `GF64_WB_DW / 8; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // New access seen, ack not yet given
  assign req  = cyc & stb & ~ack;
  assign busy = (state == ISSUE) || (state == WAIT);
  assign done = (state == DONE);

  assign operands.x = a_reg;
  assign operands.y = b_reg;

  // --------------------------------------------------
  // Ack and register writes
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  // All writes dropped while a run is active
  always_ff @(posedge clk) begin
    if (rst) begin
      a_reg  <= '0;
      b_reg  <= '0;
      rounds <= '0;
      start  <= 1'b0;
    end else begin
      start <= 1'b0;
      if (req && we && !busy) begin
        case (adr)
          `GF64_REG_A_LO: a_reg[`GF64_WB_DW-1:0] <= lane_merge(a_reg[`GF64_WB_DW-1:0], dat_w, sel);
          `GF64_REG_A_HI: a_reg[`GF64_MOD_W-1:`GF64_WB_DW] <=
            lane_merge(a_reg[`GF64_MOD_W-1:`GF64_WB_DW], dat_w, sel);
          `GF64_REG_B_LO: b_reg[`GF64_WB_DW-1:0] <= lane_merge(b_reg[`GF64_WB_DW-1:0], dat_w, sel);
          `GF64_REG_B_HI: b_reg[`GF64_MOD_W-1:`GF64_WB_DW] <=
            lane_merge(b_reg[`GF64_MOD_W-1:`GF64_WB_DW], dat_w, sel);
          `GF64_REG_CTRL: begin
            rounds <= dat_w[`GF64_ROUND_W-1:0];
            start  <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    rd_data = '0;
    case (adr)
      `GF64_REG_A_LO:   rd_data = a_reg[`GF64_WB_DW-1:0];
      `GF64_REG_A_HI:   rd_data = a_reg[`GF64_MOD_W-1:`GF64_WB_DW];
      `GF64_REG_B_LO:   rd_data = b_reg[`GF64_WB_DW-1:0];
      `GF64_REG_B_HI:   rd_data = b_reg[`GF64_MOD_W-1:`GF64_WB_DW];
      `GF64_REG_CTRL:   rd_data = {{(`GF64_WB_DW - `GF64_ROUND_W){1'b0}}, rounds};
      `GF64_REG_STATUS: rd_data = {{(`GF64_WB_DW - 2){1'b0}}, done, busy};
      `GF64_REG_X_LO:   rd_data = pair.x[`GF64_WB_DW-1:0];
      `GF64_REG_X_HI:   rd_data = pair.x[`GF64_MOD_W-1:`GF64_WB_DW];
      `GF64_REG_Y_LO:   rd_data = pair.y[`GF64_WB_DW-1:0];
      `GF64_REG_Y_HI:   rd_data = pair.y[`GF64_MOD_W-1:`GF64_WB_DW];
      default:          rd_data = '0;
    endcase
  end

  // Read data captured with the ack edge
  always_ff @(posedge clk) begin
    if (req) begin
      dat_r <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/gf64_bfly_top.sv ====
/*
 * Top level of the GF64 butterfly accelerator.
 * Wishbone classic slave in front of the sequencer, round counter and butterfly unit.
 */
`timescale 1ns/1ns
`default_nettype none
`include "gf64_settings.svh"

module gf64_bfly_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`GF64_WB_AW-1:0]   adr,
  input  logic [`GF64_WB_DW-1:0]   dat_w,
  input  logic [`GF64_WB_DW/8-1:0] sel,
  output logic [`GF64_WB_DW-1:0]   dat_r,
  output logic                     ack
);
  import gf64_pkg::*;

  gf64_pair_t               operands;
  gf64_pair_t               pair;
  gf64_seq_state_t          state;
  logic [`GF64_ROUND_W-1:0] rounds;
  logic                     start;
  logic                     load;
  logic                     cnt_load;
  logic                     issue;
  logic                     dec;
  logic                     zero;
  logic                     round_done;

  // --------------------------------------------------
  // Host side
  // --------------------------------------------------
  gf64_wb_regs gf64_wb_regs_i (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .sel      (sel),
    .dat_r    (dat_r),
    .ack      (ack),
    .state    (state),
    .pair     (pair),
    .operands (operands),
    .start    (start),
    .rounds   (rounds)
  );

  // --------------------------------------------------
  // Engine
  // --------------------------------------------------
  gf64_sequencer gf64_sequencer_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .zero       (zero),
    .round_done (round_done),
    .load       (load),
    .cnt_load   (cnt_load),
    .issue      (issue),
    .dec        (dec),
    .state      (state)
  );

  gf64_round_counter gf64_round_counter_i (
    .clk      (clk),
    .rst      (rst),
    .cnt_load (cnt_load),
    .rounds   (rounds),
    .dec      (dec),
    .zero     (zero)
  );

  gf64_bfly_unit gf64_bfly_unit_i (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .operands   (operands),
    .issue      (issue),
    .pair       (pair),
    .round_done (round_done)
  );

endmodule

`default_nettype wire

// ==== tests/gf64_bfly_tb.sv ====
/*
 * Self-checking testbench of the GF64 butterfly accelerator.
 * Runs register, file-vector, random and busy-write tests over Wishbone.
 */
`timescale 1ns/1ns
`default_nettype none
`include "gf64_settings.svh"

module gf64_bfly_tb;

  localparam int ACK_LIMIT   = 16;
  localparam int POLL_LIMIT  = 4 * 256;
  localparam int FILE_MAX    = 24;
  localparam int NUM_RAND    = 8;
  localparam int NUM_TESTS   = FILE_MAX + NUM_RAND + 4;
  localparam int WDOG_CYCLES = NUM_TESTS * (4 * 255 + 40);

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  adr;
  logic [31:0] dat_w;
  logic [3:0]  sel;
  logic [31:0] dat_r;
  logic        ack;
  logic [31:0] lfsr;
  int          check_count;
  int          error_count;

  gf64_bfly_top gf64_bfly_top_i (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .sel   (sel),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Ends a run that stalls somewhere
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired: run did not finish within %0d cycles", WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------
  // Galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Iterated butterfly on wide integers, x in the upper half
  function automatic logic [127:0] model_bfly(input logic [63:0] a, input logic [63:0] b,
                                              input int r);
    logic [127:0] x;
    logic [127:0] y;
    logic [127:0] nx;
    logic [127:0] p;
    p = {64'd0, `GF64_PRIME};
    x = {64'd0, a};
    y = {64'd0, b};
    for (int i = 0; i < r; i++) begin
      nx = (x + y) % p;
      y  = (x + p - y) % p;
      x  = nx;
    end
    return {x[63:0], y[63:0]};
  endfunction

  // --------------------------------------------------
  // Bus access and checks
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got);
    check_count++;
    assert (got === exp_v) else begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp_v, got);
      error_count++;
    end
  endtask

  // Single classic cycle, held through the edge that carries ack
  task automatic bus_cycle(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, output logic [31:0] rdata);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = addr;
    dat_w = wdata;
    sel   = be;
    while (!seen && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
      if (ack) begin
        seen  = 1'b1;
        rdata = dat_r;
      end
    end
    assert (seen) else begin
      $display("No ack from the DUT within %0d cycles at register %0d", ACK_LIMIT, addr);
      error_count++;
    end
    @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_write(input logic [3:0] addr, input logic [31:0] data,
                          input logic [3:0] be);
    logic [31:0] unused;
    bus_cycle(1'b1, addr, data, be, unused);
  endtask

  task automatic wb_read(input logic [3:0] addr, output logic [31:0] data);
    bus_cycle(1'b0, addr, 32'd0, 4'hf, data);
  endtask

  task automatic read_word64(input logic [3:0] lo_addr, output logic [63:0] v);
    logic [31:0] lo;
    logic [31:0] hi;
    wb_read(lo_addr, lo);
    wb_read(lo_addr + 4'd1, hi);
    v = {hi, lo};
  endtask

  task automatic write_operands(input logic [63:0] a, input logic [63:0] b);
    wb_write(`GF64_REG_A_LO, a[31:0], 4'hf);
    wb_write(`GF64_REG_A_HI, a[63:32], 4'hf);
    wb_write(`GF64_REG_B_LO, b[31:0], 4'hf);
    wb_write(`GF64_REG_B_HI, b[63:32], 4'hf);
  endtask

  // Poll until done set and busy clear
  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    polls = 0;
    st    = '0;
    while (st[1:0] != 2'b10 && polls < POLL_LIMIT) begin
      wb_read(`GF64_REG_STATUS, st);
      polls++;
    end
    assert (st[1:0] == 2'b10) else begin
      $display("Engine did not report done within %0d status reads", POLL_LIMIT);
      error_count++;
    end
  endtask

  task automatic run_case(input logic [63:0] a, input logic [63:0] b, input logic [7:0] r,
                          input logic [63:0] exp_x, input logic [63:0] exp_y);
    logic [63:0] got;
    write_operands(a, b);
    wb_write(`GF64_REG_CTRL, {24'd0, r}, 4'hf);
    wait_done();
    read_word64(`GF64_REG_X_LO, got);
    check_value("x", exp_x, got);
    read_word64(`GF64_REG_Y_LO, got);
    check_value("y", exp_y, got);
  endtask

  // Every lane written alone, other lanes carry the inverted value
  task automatic write_by_lanes(input logic [3:0] addr, input logic [31:0] target);
    logic [31:0] data;
    for (int i = 0; i < 4; i++) begin
      data = ~target;
      data[8*i +: 8] = target[8*i +: 8];
      wb_write(addr, data, 4'b0001 << i);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int          fd;
    int          n;
    int          file_tests;
    string       line;
    logic [63:0] fa;
    logic [63:0] fb;
    logic [63:0] fx;
    logic [63:0] fy;
    logic [31:0] fr;
    logic [63:0] v;
    logic [31:0] word;
    logic [127:0] exp_pair;

    rst         = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    sel         = '0;
    lfsr        = 32'h6b48;
    check_count = 0;
    error_count = 0;
    file_tests  = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset state, byte lanes, unmapped reads
    wb_read(`GF64_REG_STATUS, word);
    check_value("status", 64'd0, {32'd0, word});
    write_by_lanes(`GF64_REG_A_LO, 32'h1234_5678);
    write_by_lanes(`GF64_REG_A_HI, 32'h9abc_def0);
    write_by_lanes(`GF64_REG_B_LO, 32'h0f1e_2d3c);
    write_by_lanes(`GF64_REG_B_HI, 32'h4b5a_6978);
    read_word64(`GF64_REG_A_LO, v);
    check_value("a_reg", 64'h9abc_def0_1234_5678, v);
    read_word64(`GF64_REG_B_LO, v);
    check_value("b_reg", 64'h4b5a_6978_0f1e_2d3c, v);
    for (int a = 10; a < 16; a++) begin
      wb_read(a[3:0], word);
      check_value("dat_r unmapped", 64'd0, {32'd0, word});
    end

    // File vectors, comment lines do not parse
    fd = $fopen("tests/gf64_bfly_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file");
      error_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h", fa, fb, fr, fx, fy);
        if (n == 5 && file_tests < FILE_MAX) begin
          run_case(fa, fb, fr[7:0], fx, fy);
          file_tests++;
        end
      end
      $fclose(fd);
    end
    if (file_tests == 0) begin
      $display("No test vectors were read from the file");
      error_count++;
    end

    // Random canonical pairs, R from 2 to 255
    for (int t = 0; t < NUM_RAND; t++) begin
      draw_bits(64, fa);
      if (fa >= `GF64_PRIME) fa = fa - `GF64_PRIME;
      draw_bits(64, fb);
      if (fb >= `GF64_PRIME) fb = fb - `GF64_PRIME;
      draw_bits(8, v);
      fr = (v[7:0] < 8'd2) ? 32'd2 : {24'd0, v[7:0]};
      exp_pair = model_bfly(fa, fb, fr);
      run_case(fa, fb, fr[7:0], exp_pair[127:64], exp_pair[63:0]);
    end

    // Writes during a long run are dropped
    write_operands(64'd1, 64'd0);
    wb_write(`GF64_REG_CTRL, 32'd255, 4'hf);
    wb_read(`GF64_REG_STATUS, word);
    check_value("status.busy", 64'd1, {63'd0, word[0]});
    wb_write(`GF64_REG_A_LO, 32'hdead_beef, 4'hf);
    wb_write(`GF64_REG_B_HI, 32'h0bad_f00d, 4'hf);
    wb_write(`GF64_REG_CTRL, 32'd1, 4'hf);
    wait_done();
    read_word64(`GF64_REG_X_LO, v);
    check_value("x", 64'hFFFF_FFFE_8000_0001, v);
    read_word64(`GF64_REG_Y_LO, v);
    check_value("y", 64'hFFFF_FFFE_8000_0001, v);
    read_word64(`GF64_REG_A_LO, v);
    check_value("a_reg", 64'd1, v);
    read_word64(`GF64_REG_B_LO, v);
    check_value("b_reg", 64'd0, v);

    $display("Checks: %0d, errors: %0d, file vectors: %0d", check_count, error_count,
             file_tests);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gf64_bfly_top.f ====
+incdir+logic
logic/gf64_pkg.sv
logic/gf64_pmr_sign.sv
logic/gf64_bfly_unit.sv
logic/gf64_round_counter.sv
logic/gf64_sequencer.sv
logic/gf64_wb_regs.sv
logic/gf64_bfly_top.sv
tests/gf64_bfly_tb.sv

// ==== tests/gf64_bfly_input.txt ====
// A B R(hex) expected_X expected_Y, all hex, one butterfly run per line
// X and Y are (A, B) after R rounds of (x, y) -> (x + y, x - y) mod p
FFFFFFFF00000000 8000000000000000 00 FFFFFFFF00000000 8000000000000000
0000000100000000 0000000000000001 00 0000000100000000 0000000000000001
0000000000000000 0000000000000000 01 0000000000000000 0000000000000000
0000000000000000 0000000000000001 01 0000000000000001 FFFFFFFF00000000
0000000000000001 0000000000000000 01 0000000000000001 0000000000000001
FFFFFFFF00000000 0000000000000001 01 0000000000000000 FFFFFFFEFFFFFFFF
FFFFFFFF00000000 FFFFFFFF00000000 01 FFFFFFFEFFFFFFFF 0000000000000000
0000000000000001 FFFFFFFF00000000 01 0000000000000000 0000000000000002
8000000000000000 8000000000000000 01 00000000FFFFFFFF 0000000000000000
0000000100000000 8000000000000000 01 8000000100000000 8000000000000001
0000000000000000 8000000000000000 01 8000000000000000 7FFFFFFF00000001
FFFFFFFF00000000 0000000100000000 01 00000000FFFFFFFF FFFFFFFE00000000
8000000000000000 FFFFFFFF00000000 01 7FFFFFFFFFFFFFFF 8000000000000001
FFFFFFFF00000000 0000000000000001 02 FFFFFFFEFFFFFFFF 0000000000000002
8000000000000000 0000000100000000 02 00000000FFFFFFFF 0000000200000000
0000000000000007 0000000000000009 03 0000000000000020 FFFFFFFEFFFFFFFD
0000000100000000 0000000000000001 40 00000000FFFFFFFF 0000000100000000
0000000000000001 0000000000000002 80 00000000FFFFFFFF 00000001FFFFFFFE
0000000000000001 0000000100000000 C0 FFFFFFFF00000000 FFFFFFFE00000001
0000000000000005 0000000000000003 C1 FFFFFFFEFFFFFFF9 FFFFFFFEFFFFFFFF
0000000000000001 0000000000000000 FF FFFFFFFE80000001 FFFFFFFE80000001
0000000000000001 0000000000000001 FF FFFFFFFE00000001 0000000000000000
